//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = decode_stage_tb
FILELIST  = sim.f
PASS_MSG  = Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- logic/ctrl_decode.sv
module ctrl_decode
(
  input  logic [5:0]                  opcode,
  output logic [ctrl_pkg::CTRL_W-1:0] ctrl
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  function automatic logic [ALU_W-1:0] alu_of(input logic [5:0] op);
    case (op)
      op_ld, op_st, op_add, op_addi: alu_of = alu_add;
      op_sub, op_subi:               alu_of = alu_sub;
      op_mul, op_muli:               alu_of = alu_mul;
      op_div, op_divi:               alu_of = alu_div;
      op_mod, op_modi:               alu_of = alu_mod;
      op_shl, op_shli:               alu_of = alu_shl;
      op_shr, op_shri:               alu_of = alu_shr;
      op_and, op_andi:               alu_of = alu_and;
      op_or, op_ori:                 alu_of = alu_or;
      op_xor, op_xori:               alu_of = alu_xor;
      op_neg:                        alu_of = alu_neg;
      op_not:                        alu_of = alu_not;
      op_ldi:                        alu_of = alu_ldi;
      op_jali, op_jalr:              alu_of = alu_link;
      op_andp:                       alu_of = 4'd1;  // pred ops share 1..4
      op_orp:                        alu_of = 4'd2;
      op_xorp:                       alu_of = 4'd3;
      op_notp:                       alu_of = 4'd4;
      op_rtop:                       alu_of = 4'd5;  // value tests on 5..7
      op_isneg:                      alu_of = 4'd6;
      op_iszero:                     alu_of = 4'd7;
      default:                       alu_of = '0;
    endcase
  endfunction

  always_comb
  begin
    ctrl = '0;
    ctrl[EX_ALU_LO +: ALU_W] = alu_of(opcode);
    case (opcode)
      op_ld:
      begin
        ctrl[OPC_LO +: OPC_W] = 2'b01;
        ctrl[WB_REG_MEM]      = 1'b1;
        ctrl[WB_RW_R]         = 1'b1;
        ctrl[MEM_READ]        = 1'b1;
        ctrl[EX_PF_OR_I]      = 1'b1;
        ctrl[EX_SRC2_IMM]     = 1'b1;
        ctrl[IMM_LO +: 2]     = imm_s15;
      end
      op_st:
      begin
        ctrl[OPC_LO +: OPC_W] = 2'b11;
        ctrl[MEM_WRITE]       = 1'b1;
        ctrl[EX_PF_OR_I]      = 1'b1;
        ctrl[EX_SRC2_IMM]     = 1'b1;
        ctrl[IMM_LO +: 2]     = imm_s15;
        ctrl[X_SEL]           = 1'b1;  // store data sits in rz
      end
      op_andp, op_orp, op_xorp, op_notp:
        ctrl[WB_RW_P] = 1'b1;
      op_rtop, op_isneg, op_iszero:
      begin
        ctrl[OPC_LO +: OPC_W] = 2'b01;
        ctrl[WB_RW_P]         = 1'b1;
      end
      op_ldi:
      begin
        ctrl[WB_RW_R]     = 1'b1;
        ctrl[EX_PF_OR_I]  = 1'b1;
        ctrl[EX_SRC2_IMM] = 1'b1;
        ctrl[IMM_LO +: 2] = imm_s19;
      end
      op_addi, op_subi, op_muli, op_divi, op_modi, op_shli, op_shri,
      op_andi, op_ori, op_xori:
      begin
        ctrl[OPC_LO +: OPC_W] = 2'b01;
        ctrl[WB_RW_R]         = 1'b1;
        ctrl[EX_PF_OR_I]      = 1'b1;
        ctrl[EX_SRC2_IMM]     = 1'b1;
        ctrl[IMM_LO +: 2]     = imm_s15;
      end
      op_add, op_sub, op_mul, op_div, op_mod, op_shl, op_shr,
      op_and, op_or, op_xor:
      begin
        ctrl[OPC_LO +: OPC_W] = 2'b11;
        ctrl[WB_RW_R]         = 1'b1;
        ctrl[EX_PF_OR_I]      = 1'b1;
      end
      op_neg, op_not:
      begin
        ctrl[OPC_LO +: OPC_W] = 2'b01;
        ctrl[WB_RW_R]         = 1'b1;
        ctrl[EX_PF_OR_I]      = 1'b1;
      end
      op_jmpi:
      begin
        ctrl[JMP_LO +: JMP_W] = 2'b11;
        ctrl[IMM_LO +: 2]     = imm_s23;
      end
      op_jmpr:
      begin
        ctrl[OPC_LO +: OPC_W] = 2'b10;
        ctrl[JMP_LO +: JMP_W] = 2'b01;
        ctrl[X_SEL]           = 1'b1;  // target reg in rz slot
      end
      op_jali, op_jalr:
      begin
        ctrl[WB_RW_R]    = 1'b1;
        ctrl[EX_LINK]    = 1'b1;
        ctrl[EX_PF_OR_I] = 1'b1;
        if (opcode == op_jali)
        begin
          ctrl[JMP_LO +: JMP_W] = 2'b11;
          ctrl[IMM_LO +: 2]     = imm_s19;
        end
        else
        begin
          ctrl[OPC_LO +: OPC_W] = 2'b10;
          ctrl[JMP_LO +: JMP_W] = 2'b01;
        end
      end
      default:
        ctrl = '0;  // float and unknown opcodes run as nop
    endcase
  end

endmodule

//--- logic/ctrl_pkg.sv
package ctrl_pkg;

  localparam int CTRL_W = 19;

  // field low bits
  localparam int X_SEL  = 0;
  localparam int IMM_LO = 1;
  localparam int JMP_LO = 3;   // 3 is_jump, 4 imm_form
  localparam int EX_LO  = 5;
  localparam int MEM_LO = 12;
  localparam int WB_LO  = 14;
  localparam int OPC_LO = 17;  // 17 has_ry, 18 has_rx

  localparam int EX_W  = 7;
  localparam int MEM_W = 2;
  localparam int WB_W  = 3;
  localparam int JMP_W = 2;
  localparam int OPC_W = 2;

  // single bits inside the ex, mem and wb fields
  localparam int EX_PF_OR_I  = 5;
  localparam int EX_ALU_LO   = 6;
  localparam int ALU_W       = 4;
  localparam int EX_SRC2_IMM = 10;
  localparam int EX_LINK     = 11;
  localparam int MEM_READ    = 12;
  localparam int MEM_WRITE   = 13;
  localparam int WB_REG_MEM  = 14;
  localparam int WB_RW_P     = 15;
  localparam int WB_RW_R     = 16;

  localparam logic [ALU_W-1:0] alu_add  = 4'd1;
  localparam logic [ALU_W-1:0] alu_sub  = 4'd2;
  localparam logic [ALU_W-1:0] alu_mul  = 4'd3;
  localparam logic [ALU_W-1:0] alu_div  = 4'd4;
  localparam logic [ALU_W-1:0] alu_mod  = 4'd5;
  localparam logic [ALU_W-1:0] alu_shl  = 4'd6;
  localparam logic [ALU_W-1:0] alu_shr  = 4'd7;
  localparam logic [ALU_W-1:0] alu_and  = 4'd8;
  localparam logic [ALU_W-1:0] alu_or   = 4'd9;
  localparam logic [ALU_W-1:0] alu_xor  = 4'd10;
  localparam logic [ALU_W-1:0] alu_neg  = 4'd11;
  localparam logic [ALU_W-1:0] alu_not  = 4'd12;
  localparam logic [ALU_W-1:0] alu_ldi  = 4'd13;
  localparam logic [ALU_W-1:0] alu_link = 4'd14;

endpackage

//--- logic/decode_stage.sv
module decode_stage #(
  parameter int DATA_W = 32
)
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_req,
  input  isa_pkg::inst_word_u           in_inst,
  input  logic [DATA_W-1:0]             in_pc_n,
  input  logic                          out_ack,
  input  logic                          wb_greg_en,
  input  logic [isa_pkg::REG_ID_W-1:0]  wb_greg_id,
  input  logic [DATA_W-1:0]             wb_greg_data,
  input  logic                          wb_preg_en,
  input  logic [isa_pkg::PREG_ID_W-1:0] wb_preg_id,
  input  logic                          wb_preg_data,
  output logic                          in_ack,
  output logic                          out_req,
  output logic [ctrl_pkg::EX_W-1:0]     out_ex,
  output logic [ctrl_pkg::MEM_W-1:0]    out_mem,
  output logic [ctrl_pkg::WB_W-1:0]     out_wb,
  output logic [ctrl_pkg::JMP_W-1:0]    out_jmp,
  output logic [ctrl_pkg::OPC_W-1:0]    out_opc_type,
  output logic [DATA_W-1:0]             out_rx,
  output logic [DATA_W-1:0]             out_ry,
  output logic                          out_px,
  output logic                          out_py,
  output logic                          out_pval,
  output logic [isa_pkg::REG_ID_W-1:0]  out_rz_id,
  output logic [isa_pkg::REG_ID_W-1:0]  out_x_id,
  output logic [isa_pkg::REG_ID_W-1:0]  out_y_id,
  output logic [DATA_W-1:0]             out_imm,
  output logic [DATA_W-1:0]             out_jmp_target
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  logic                lat_valid;
  logic                lat_take;
  inst_word_u          lat_inst;
  logic [DATA_W-1:0]   lat_pc_n;
  logic [CTRL_W-1:0]   ctrl;
  imm_kind_e           kind;
  logic [EX_W-1:0]     ex;
  logic [MEM_W-1:0]    mem;
  logic [WB_W-1:0]     wb;
  logic [JMP_W-1:0]    jmp;
  logic [OPC_W-1:0]    opc_type;
  logic [DATA_W-1:0]   rx;
  logic [DATA_W-1:0]   ry;
  logic                px;
  logic                py;
  logic                pval;
  logic [REG_ID_W-1:0] rz_id;
  logic [REG_ID_W-1:0] x_id;
  logic [REG_ID_W-1:0] y_id;
  logic [DATA_W-1:0]   imm;
  logic [DATA_W-1:0]   jmp_target;

  assign kind     = imm_kind_e'(ctrl[IMM_LO +: $bits(imm_kind_e)]);
  assign ex       = ctrl[EX_LO +: EX_W];
  assign mem      = ctrl[MEM_LO +: MEM_W];
  assign wb       = ctrl[WB_LO +: WB_W];
  assign jmp      = ctrl[JMP_LO +: JMP_W];
  assign opc_type = ctrl[OPC_LO +: OPC_W];
  assign rz_id    = lat_inst.r.rz;

  inst_latch #(.DATA_W(DATA_W)) u_inst_latch (.*);

  ctrl_decode u_ctrl_decode (
    .opcode (lat_inst.r.opcode),
    .ctrl   (ctrl)
  );

  reg_read #(.DATA_W(DATA_W)) u_reg_read (
    .*,
    .inst  (lat_inst),
    .x_sel (ctrl[X_SEL])
  );

  imm_gen #(.DATA_W(DATA_W)) u_imm_gen (
    .inst       (lat_inst),
    .kind       (kind),
    .pc_n       (lat_pc_n),
    .imm        (imm),
    .jmp_target (jmp_target)
  );

  issue_reg #(.DATA_W(DATA_W)) u_issue_reg (.*);

endmodule

//--- logic/imm_gen.sv
module imm_gen #(
  parameter int DATA_W = 32
)
(
  input  isa_pkg::inst_word_u inst,
  input  isa_pkg::imm_kind_e  kind,
  input  logic [DATA_W-1:0]   pc_n,
  output logic [DATA_W-1:0]   imm,
  output logic [DATA_W-1:0]   jmp_target
);
  import isa_pkg::*;

  always_comb
  begin
    case (kind)
      imm_s15: imm = {{(DATA_W-15){inst.i.imm23[14]}}, inst.i.imm23[14:0]};
      imm_s19: imm = {{(DATA_W-19){inst.i.imm23[18]}}, inst.i.imm23[18:0]};
      imm_s23: imm = {{(DATA_W-23){inst.i.imm23[22]}}, inst.i.imm23[22:0]};
      default: imm = '0;
    endcase
  end

  assign jmp_target = pc_n + imm;  // wraps

endmodule

//--- logic/inst_latch.sv
module inst_latch #(
  parameter int DATA_W = 32
)
(
  input  logic                clk,
  input  logic                rst,
  input  logic                in_req,
  input  isa_pkg::inst_word_u in_inst,
  input  logic [DATA_W-1:0]   in_pc_n,
  input  logic                lat_take,
  output logic                in_ack,
  output logic                lat_valid,
  output isa_pkg::inst_word_u lat_inst,
  output logic [DATA_W-1:0]   lat_pc_n
);

  logic capture;

  // new word only when empty and the last handshake has closed
  assign capture = in_req && !in_ack && !lat_valid;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      in_ack    <= 1'b0;
      lat_valid <= 1'b0;
    end
    else if (capture)
    begin
      in_ack    <= 1'b1;
      lat_valid <= 1'b1;
    end
    else
    begin
      if (!in_req)
        in_ack <= 1'b0;     // req dropped, finish four-phase
      if (lat_take)
        lat_valid <= 1'b0;  // issue reg took it
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      lat_inst <= in_inst;
      lat_pc_n <= in_pc_n;
    end
  end

endmodule

//--- logic/isa_pkg.sv
package isa_pkg;

  localparam int INST_W = 32;
  localparam int REG_ID_W = 4, PREG_ID_W = 2;
  localparam int NUM_GREGS = 16, NUM_PREGS = 4;

  // memory
  localparam logic [5:0] op_ld     = 6'h23;
  localparam logic [5:0] op_st     = 6'h24;
  // predicate logic
  localparam logic [5:0] op_andp   = 6'h27;
  localparam logic [5:0] op_orp    = 6'h28;
  localparam logic [5:0] op_xorp   = 6'h29;
  localparam logic [5:0] op_notp   = 6'h2a;
  // value tests
  localparam logic [5:0] op_rtop   = 6'h26;
  localparam logic [5:0] op_isneg  = 6'h2b;
  localparam logic [5:0] op_iszero = 6'h2c;
  // immediate alu
  localparam logic [5:0] op_ldi    = 6'h25;
  localparam logic [5:0] op_addi   = 6'h14;
  localparam logic [5:0] op_subi   = 6'h15;
  localparam logic [5:0] op_muli   = 6'h16;
  localparam logic [5:0] op_divi   = 6'h17;
  localparam logic [5:0] op_modi   = 6'h18;
  localparam logic [5:0] op_shli   = 6'h19;
  localparam logic [5:0] op_shri   = 6'h1a;
  localparam logic [5:0] op_andi   = 6'h11;
  localparam logic [5:0] op_ori    = 6'h12;
  localparam logic [5:0] op_xori   = 6'h13;
  // register alu
  localparam logic [5:0] op_and    = 6'h07;
  localparam logic [5:0] op_or     = 6'h08;
  localparam logic [5:0] op_xor    = 6'h09;
  localparam logic [5:0] op_add    = 6'h0a;
  localparam logic [5:0] op_sub    = 6'h0b;
  localparam logic [5:0] op_mul    = 6'h0c;
  localparam logic [5:0] op_div    = 6'h0d;
  localparam logic [5:0] op_mod    = 6'h0e;
  localparam logic [5:0] op_shl    = 6'h0f;
  localparam logic [5:0] op_shr    = 6'h10;
  localparam logic [5:0] op_neg    = 6'h05;
  localparam logic [5:0] op_not    = 6'h06;
  // control flow
  localparam logic [5:0] op_jmpi   = 6'h1d;
  localparam logic [5:0] op_jmpr   = 6'h1e;
  localparam logic [5:0] op_jali   = 6'h1b;
  localparam logic [5:0] op_jalr   = 6'h1c;

  typedef enum logic [1:0] {
    imm_none = 2'b00,
    imm_s15  = 2'b01,
    imm_s23  = 2'b10,
    imm_s19  = 2'b11
  } imm_kind_e;

  typedef struct packed {
    logic                 pset;
    logic [PREG_ID_W-1:0] pid;
    logic [5:0]           opcode;
    logic [REG_ID_W-1:0]  rz;
    logic [REG_ID_W-1:0]  ry;
    logic [REG_ID_W-1:0]  rx;
    logic [10:0]          spare;
  } inst_reg_t;

  typedef struct packed {
    logic                 pset;
    logic [PREG_ID_W-1:0] pid;
    logic [5:0]           opcode;
    logic [INST_W-10:0]   imm23;  // bits 22:0
  } inst_imm_t;

  typedef union packed {
    inst_reg_t r;
    inst_imm_t i;
  } inst_word_u;

endpackage

//--- logic/issue_reg.sv
module issue_reg #(
  parameter int DATA_W = 32
)
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         lat_valid,
  input  logic                         out_ack,
  input  logic [ctrl_pkg::EX_W-1:0]    ex,
  input  logic [ctrl_pkg::MEM_W-1:0]   mem,
  input  logic [ctrl_pkg::WB_W-1:0]    wb,
  input  logic [ctrl_pkg::JMP_W-1:0]   jmp,
  input  logic [ctrl_pkg::OPC_W-1:0]   opc_type,
  input  logic [DATA_W-1:0]            rx,
  input  logic [DATA_W-1:0]            ry,
  input  logic                         px,
  input  logic                         py,
  input  logic                         pval,
  input  logic [isa_pkg::REG_ID_W-1:0] rz_id,
  input  logic [isa_pkg::REG_ID_W-1:0] x_id,
  input  logic [isa_pkg::REG_ID_W-1:0] y_id,
  input  logic [DATA_W-1:0]            imm,
  input  logic [DATA_W-1:0]            jmp_target,
  output logic                         lat_take,
  output logic                         out_req,
  output logic [ctrl_pkg::EX_W-1:0]    out_ex,
  output logic [ctrl_pkg::MEM_W-1:0]   out_mem,
  output logic [ctrl_pkg::WB_W-1:0]    out_wb,
  output logic [ctrl_pkg::JMP_W-1:0]   out_jmp,
  output logic [ctrl_pkg::OPC_W-1:0]   out_opc_type,
  output logic [DATA_W-1:0]            out_rx,
  output logic [DATA_W-1:0]            out_ry,
  output logic                         out_px,
  output logic                         out_py,
  output logic                         out_pval,
  output logic [isa_pkg::REG_ID_W-1:0] out_rz_id,
  output logic [isa_pkg::REG_ID_W-1:0] out_x_id,
  output logic [isa_pkg::REG_ID_W-1:0] out_y_id,
  output logic [DATA_W-1:0]            out_imm,
  output logic [DATA_W-1:0]            out_jmp_target
);

  logic full;

  assign lat_take = lat_valid && !full;  // high for the single load cycle

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      full    <= 1'b0;
      out_req <= 1'b0;
    end
    else if (lat_take)
    begin
      full    <= 1'b1;
      out_req <= 1'b1;
    end
    else if (out_req && out_ack)
      out_req <= 1'b0;
    else if (full && !out_req && !out_ack)
      full <= 1'b0;  // execute released ack
  end

  always_ff @(posedge clk)
  begin
    if (lat_take)
    begin
      out_ex         <= ex;
      out_mem        <= mem;
      out_wb         <= wb;
      out_jmp        <= jmp;
      out_opc_type   <= opc_type;
      out_rx         <= rx;
      out_ry         <= ry;
      out_px         <= px;
      out_py         <= py;
      out_pval       <= pval;
      out_rz_id      <= rz_id;
      out_x_id       <= x_id;
      out_y_id       <= y_id;
      out_imm        <= imm;
      out_jmp_target <= jmp_target;
    end
  end

endmodule

//--- logic/reg_read.sv
module reg_read #(
  parameter int DATA_W = 32
)
(
  input  logic                          clk,
  input  logic                          rst,
  input  isa_pkg::inst_word_u           inst,
  input  logic                          x_sel,
  input  logic                          wb_greg_en,
  input  logic [isa_pkg::REG_ID_W-1:0]  wb_greg_id,
  input  logic [DATA_W-1:0]             wb_greg_data,
  input  logic                          wb_preg_en,
  input  logic [isa_pkg::PREG_ID_W-1:0] wb_preg_id,
  input  logic                          wb_preg_data,
  output logic [DATA_W-1:0]             rx,
  output logic [DATA_W-1:0]             ry,
  output logic                          px,
  output logic                          py,
  output logic                          pval,
  output logic [isa_pkg::REG_ID_W-1:0]  x_id,
  output logic [isa_pkg::REG_ID_W-1:0]  y_id
);
  import isa_pkg::*;

  logic [DATA_W-1:0]    gregs [NUM_GREGS];
  logic [NUM_PREGS-1:0] pregs;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_GREGS; i++)
        gregs[i] <= DATA_W'(i);       // r<i> starts at i
      pregs <= NUM_PREGS'(2'b11);   // only p0 and p1 start true
    end
    else
    begin
      if (wb_greg_en)
        gregs[wb_greg_id] <= wb_greg_data;
      if (wb_preg_en)
        pregs[wb_preg_id] <= wb_preg_data;
    end
  end

  assign x_id = x_sel ? inst.r.rz : inst.r.rx;
  assign y_id = inst.r.ry;

  // no bypass, a same-edge write shows up next cycle
  assign rx = gregs[x_id];
  assign ry = gregs[y_id];
  assign px = pregs[x_id[PREG_ID_W-1:0]];
  assign py = pregs[y_id[PREG_ID_W-1:0]];

  assign pval = inst.r.pset ? pregs[inst.r.pid] : 1'b1;  // unguarded runs

endmodule

//--- sim.f
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/inst_latch.sv
logic/ctrl_decode.sv
logic/reg_read.sv
logic/imm_gen.sv
logic/issue_reg.sv
logic/decode_stage.sv
testbench/decode_stage_assert.sv
testbench/decode_stage_tb.sv

//--- testbench/decode_stage_assert.sv
module decode_stage_assert #(
  parameter int DATA_W = 32
)
(
  input logic              clk,
  input logic              rst,
  input logic              in_req,
  input logic              in_ack,
  input logic              out_req,
  input logic              out_ack,
  input logic [6:0]        out_ex,
  input logic [6:0]        out_misc,  // mem, wb, jmp
  input logic [DATA_W-1:0] out_rx,
  input logic [DATA_W-1:0] out_imm,
  input logic [DATA_W-1:0] out_jmp_target
);

  // bundle held while waiting for ack
  bundle_stable: assert property (@(posedge clk) disable iff (rst)
    out_req && !out_ack |=> $stable({out_ex, out_misc, out_rx, out_imm, out_jmp_target}))
    else $error("bundle changed while out_req waited for ack");

  req_needs_ack: assert property (@(posedge clk) disable iff (rst)
    $fell(out_req) |-> $past(out_ack))
    else $error("out_req fell before out_ack");

  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(in_ack) |-> $past(in_req))
    else $error("in_ack rose without in_req");

endmodule

bind decode_stage decode_stage_assert #(.DATA_W(DATA_W)) u_decode_stage_assert (
  .clk            (clk),
  .rst            (rst),
  .in_req         (in_req),
  .in_ack         (in_ack),
  .out_req        (out_req),
  .out_ack        (out_ack),
  .out_ex         (out_ex),
  .out_misc       ({out_mem, out_wb, out_jmp}),
  .out_rx         (out_rx),
  .out_imm        (out_imm),
  .out_jmp_target (out_jmp_target)
);

//--- testbench/decode_stage_tb.sv
module decode_stage_tb;
  import isa_pkg::*;
  import ctrl_pkg::*;

  localparam int DATA_W = 32;
  localparam int NUM = 18;
  localparam int MAX_DLY = 5;
  localparam int RST_CYC = 5;

  typedef struct {
    logic [31:0] inst;
    logic [31:0] pc;
    int          dly;   // negative means random
    logic [6:0]  ex;
    logic [1:0]  mem;
    logic [2:0]  wb;
    logic [1:0]  jmp;
    logic [1:0]  opc;
    logic [3:0]  xid;
    int          iw;    // immediate width or 0 for none
    bit          wb_en; // writeback before this entry
  } entry_t;

  logic clk;
  logic rst;
  logic in_req;
  inst_word_u in_inst;
  logic [DATA_W-1:0] in_pc_n;
  logic out_ack;
  logic wb_greg_en;
  logic [REG_ID_W-1:0] wb_greg_id;
  logic [DATA_W-1:0] wb_greg_data;
  logic wb_preg_en;
  logic [PREG_ID_W-1:0] wb_preg_id;
  logic wb_preg_data;
  logic in_ack;
  logic out_req;
  logic [EX_W-1:0] out_ex;
  logic [MEM_W-1:0] out_mem;
  logic [WB_W-1:0] out_wb;
  logic [JMP_W-1:0] out_jmp;
  logic [OPC_W-1:0] out_opc_type;
  logic [DATA_W-1:0] out_rx;
  logic [DATA_W-1:0] out_ry;
  logic out_px;
  logic out_py;
  logic out_pval;
  logic [REG_ID_W-1:0] out_rz_id;
  logic [REG_ID_W-1:0] out_x_id;
  logic [REG_ID_W-1:0] out_y_id;
  logic [DATA_W-1:0] out_imm;
  logic [DATA_W-1:0] out_jmp_target;

  entry_t tbl [NUM];
  logic [31:0] exp_rx [NUM];
  logic [31:0] exp_ry [NUM];
  logic [31:0] exp_imm [NUM];
  logic exp_px [NUM];
  logic exp_py [NUM];
  logic exp_pval [NUM];

  decode_stage #(.DATA_W(DATA_W)) u_decode_stage (.*);

  function automatic logic [31:0] enc(bit pset, logic [1:0] pid, logic [5:0] op,
                                      logic [22:0] f);
    enc = {pset, pid, op, f};
  endfunction

  function automatic logic [22:0] regf(logic [3:0] rz, logic [3:0] ry, logic [3:0] rx);
    regf = {rz, ry, rx, 11'b0};
  endfunction

  function automatic logic [6:0] exf(bit link, bit src2, logic [3:0] alu, bit pf);
    exf = {link, src2, alu, pf};
  endfunction

  function automatic logic [31:0] sext(logic [22:0] f, int w);
    case (w)
      15: sext = {{17{f[14]}}, f[14:0]};
      19: sext = {{13{f[18]}}, f[18:0]};
      23: sext = {{9{f[22]}}, f[22:0]};
      default: sext = '0;
    endcase
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act)
    else
    begin
      $display("error %s: expected %h actual %h", name, exp, act);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fill_table();
    tbl[0]  = '{enc(0, 0, 6'h0a, regf(2, 3, 1)), 32'h100, 0, exf(0, 0, 1, 1),
                2'd0, 3'd4, 2'd0, 2'd3, 4'd1, 0, 0};
    tbl[1]  = '{enc(0, 0, 6'h24, {4'd7, 4'd2, 15'h0010}), 32'h104, 1, exf(0, 1, 1, 1),
                2'd2, 3'd0, 2'd0, 2'd3, 4'd7, 15, 0};
    tbl[2]  = '{enc(0, 0, 6'h23, {4'd4, 4'd1, 15'h7ff0}), 32'h200, 0, exf(0, 1, 1, 1),
                2'd1, 3'd5, 2'd0, 2'd1, 4'd15, 15, 0};
    tbl[3]  = '{enc(0, 0, 6'h25, 23'h1c0001), 32'h204, 2, exf(0, 1, 13, 1),
                2'd0, 3'd4, 2'd0, 2'd0, 4'd0, 19, 0};
    tbl[4]  = '{enc(0, 0, 6'h1d, 23'h7ffffc), 32'h1000, 0, exf(0, 0, 0, 0),
                2'd0, 3'd0, 2'd3, 2'd0, 4'd15, 23, 0};
    tbl[5]  = '{enc(0, 0, 6'h1e, regf(9, 0, 0)), 32'h1004, 1, exf(0, 0, 0, 0),
                2'd0, 3'd0, 2'd1, 2'd2, 4'd9, 0, 0};
    tbl[6]  = '{enc(0, 0, 6'h1b, 23'h000123), 32'h2000, 0, exf(1, 0, 14, 1),
                2'd0, 3'd4, 2'd3, 2'd0, 4'd0, 19, 0};
    tbl[7]  = '{enc(0, 0, 6'h1c, regf(1, 2, 3)), 32'h2004, 3, exf(1, 0, 14, 1),
                2'd0, 3'd4, 2'd1, 2'd2, 4'd3, 0, 0};
    tbl[8]  = '{enc(1, 2, 6'h27, regf(1, 0, 1)), 32'h2008, 0, exf(0, 0, 1, 0),
                2'd0, 3'd2, 2'd0, 2'd0, 4'd1, 0, 0};
    tbl[9]  = '{enc(1, 1, 6'h2b, regf(0, 6, 2)), 32'h200c, 0, exf(0, 0, 6, 0),
                2'd0, 3'd2, 2'd0, 2'd1, 4'd2, 0, 0};
    tbl[10] = '{enc(1, 3, 6'h14, {4'd8, 4'd4, 15'h1234}), 32'h2010, 1, exf(0, 1, 1, 1),
                2'd0, 3'd4, 2'd0, 2'd1, 4'd2, 15, 0};
    tbl[11] = '{enc(0, 0, 6'h05, regf(6, 0, 7)), 32'h2014, 0, exf(0, 0, 11, 1),
                2'd0, 3'd4, 2'd0, 2'd1, 4'd7, 0, 0};
    tbl[12] = '{enc(1, 0, 6'h35, regf(4, 2, 1)), 32'h2018, 0, exf(0, 0, 0, 0),
                2'd0, 3'd0, 2'd0, 2'd0, 4'd1, 0, 0};  // fadd is a nop
    tbl[13] = '{enc(1, 3, 6'h0b, regf(10, 3, 5)), 32'h201c, 0, exf(0, 0, 2, 1),
                2'd0, 3'd4, 2'd0, 2'd3, 4'd5, 0, 1};
    tbl[14] = '{enc(0, 0, 6'h09, regf(11, 12, 13)), 32'h3000, -1, exf(0, 0, 10, 1),
                2'd0, 3'd4, 2'd0, 2'd3, 4'd13, 0, 0};
    tbl[15] = '{enc(1, 0, 6'h19, {4'd2, 4'd14, 15'h4001}), 32'h3004, -1, exf(0, 1, 6, 1),
                2'd0, 3'd4, 2'd0, 2'd1, 4'd8, 15, 0};
    tbl[16] = '{enc(0, 0, 6'h28, regf(3, 1, 2)), 32'h3008, -1, exf(0, 0, 2, 0),
                2'd0, 3'd2, 2'd0, 2'd0, 4'd2, 0, 0};
    tbl[17] = '{enc(1, 3, 6'h2a, regf(0, 3, 0)), 32'h300c, -1, exf(0, 0, 4, 0),
                2'd0, 3'd2, 2'd0, 2'd0, 4'd0, 0, 0};
  endtask

  // register model walked in issue order
  task automatic build_expected();
    logic [31:0] gm [16];
    logic [3:0] pm;
    logic [3:0] yid;
    logic [1:0] pid;
    for (int i = 0; i < 16; i++)
      gm[i] = i;
    pm = 4'b0011;
    for (int k = 0; k < NUM; k++)
    begin
      if (tbl[k].wb_en)
      begin
        gm[5] = 32'hdeadbeef;
        pm[3] = 1'b1;
      end
      yid = tbl[k].inst[18:15];
      pid = tbl[k].inst[30:29];
      exp_rx[k] = gm[tbl[k].xid];
      exp_ry[k] = gm[yid];
      exp_px[k] = pm[tbl[k].xid[1:0]];
      exp_py[k] = pm[yid[1:0]];
      exp_pval[k] = tbl[k].inst[31] ? pm[pid] : 1'b1;
      exp_imm[k] = sext(tbl[k].inst[22:0], tbl[k].iw);
      if (tbl[k].dly < 0)
        tbl[k].dly = $urandom % (MAX_DLY + 1);
    end
  endtask

  task automatic write_back();
    @(posedge clk);
    wb_greg_en <= 1'b1;
    wb_greg_id <= 4'd5;
    wb_greg_data <= 32'hdeadbeef;
    wb_preg_en <= 1'b1;
    wb_preg_id <= 2'd3;
    wb_preg_data <= 1'b1;
    @(posedge clk);
    wb_greg_en <= 1'b0;
    wb_preg_en <= 1'b0;
  endtask

  task automatic fetch_all();
    for (int k = 0; k < NUM; k++)
    begin
      if (tbl[k].wb_en)
        write_back();
      @(posedge clk);
      in_req <= 1'b1;
      in_inst <= tbl[k].inst;
      in_pc_n <= tbl[k].pc;
      do @(posedge clk); while (!in_ack);
      in_req <= 1'b0;
      do @(posedge clk); while (in_ack);
    end
  endtask

  task automatic execute_all();
    string tn;
    for (int k = 0; k < NUM; k++)
    begin
      do @(posedge clk); while (!out_req);
      tn = $sformatf("entry%0d", k);
      check_val({tn, " ex"}, 32'(tbl[k].ex), 32'(out_ex));
      check_val({tn, " mem"}, 32'(tbl[k].mem), 32'(out_mem));
      check_val({tn, " wb"}, 32'(tbl[k].wb), 32'(out_wb));
      check_val({tn, " jmp"}, 32'(tbl[k].jmp), 32'(out_jmp));
      check_val({tn, " opc_type"}, 32'(tbl[k].opc), 32'(out_opc_type));
      check_val({tn, " x_id"}, 32'(tbl[k].xid), 32'(out_x_id));
      check_val({tn, " y_id"}, 32'(tbl[k].inst[18:15]), 32'(out_y_id));
      check_val({tn, " rz_id"}, 32'(tbl[k].inst[22:19]), 32'(out_rz_id));
      check_val({tn, " rx"}, exp_rx[k], out_rx);
      check_val({tn, " ry"}, exp_ry[k], out_ry);
      check_val({tn, " px"}, 32'(exp_px[k]), 32'(out_px));
      check_val({tn, " py"}, 32'(exp_py[k]), 32'(out_py));
      check_val({tn, " pval"}, 32'(exp_pval[k]), 32'(out_pval));
      check_val({tn, " imm"}, exp_imm[k], out_imm);
      check_val({tn, " target"}, tbl[k].pc + exp_imm[k], out_jmp_target);
      repeat (tbl[k].dly) @(posedge clk);
      out_ack <= 1'b1;
      do @(posedge clk); while (out_req);
      out_ack <= 1'b0;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    repeat (NUM * (10 + MAX_DLY) + RST_CYC) @(posedge clk);
    $display("watchdog expired before all entries were issued");
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  initial
  begin
    void'($urandom(25826));
    rst = 1'b1;
    in_req = 1'b0;
    in_inst = '0;
    in_pc_n = '0;
    out_ack = 1'b0;
    wb_greg_en = 1'b0;
    wb_greg_id = '0;
    wb_greg_data = '0;
    wb_preg_en = 1'b0;
    wb_preg_id = '0;
    wb_preg_data = 1'b0;
    fill_table();
    build_expected();
    repeat (RST_CYC) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_val("reset in_ack", 0, 32'(in_ack));
    check_val("reset out_req", 0, 32'(out_req));
    fork
      fetch_all();
      execute_all();
    join
    $display("Done: no errors");
    $finish;
  end

endmodule
